//--- verification/slc_stimulus.txt
# W addr data | R expected_data | X data pend | T S/F expected_dest expected_data
# all numbers hex, dest is addr bits 11..4
W 00000120 11110001
W 00000120 11110002
W 00000340 11110003
T S 12 11110001
T S 12 11110002
T S 34 11110003
# nothing received yet
R 00000000
X 0000a001 1
X 0000a002 0
X 0000b001 0
R 0000a001
R 0000a002
R 0000b001
R 00000000
# failure flushes the rest of the frame
W 00000560 22220001
W 00000560 22220002
W 00000560 22220003
T F 56 22220001
W 00000780 33330001
W 00000790 33330002
T S 78 33330001
T S 79 33330002
X 0000c001 1
X 0000c002 1
X 0000c003 0
R 0000c001
R 0000c002
R 0000c003
R 00000000

//--- compile.f
+incdir+verification
design/slc_pkg.sv
design/tx_queue.sv
design/rx_fifo.sv
design/layer_ctrl.sv
design/slc_top.sv
verification/tb_slc.sv

//--- Makefile
SOURCES := $(shell grep -v '^+' compile.f) verification/tb_slc_tasks.svh

.PHONY: run clean

run: obj_dir/Vtb_slc
	@out=$$(./obj_dir/Vtb_slc); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

obj_dir/Vtb_slc: compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_slc -o Vtb_slc

clean:
	rm -rf obj_dir

//--- verification/tb_slc_tasks.svh
`ifndef TB_SLC_TASKS_SVH
`define TB_SLC_TASKS_SVH

task automatic stop_run(input string why);
	$display("%s", why);
	$display("Simulation finished: FAIL");
	$fatal(1, "run stopped at first failure");
endtask

task automatic check_word(input string what, input bus_word_t got, input bus_word_t exp);
	if (got !== exp)
		stop_run($sformatf("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_dest(input string what, input node_addr_t got, input node_addr_t exp);
	if (got !== exp)
		stop_run($sformatf("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp)
		stop_run($sformatf("ERR %0d ns: %s is %b, expected %b", $time, what, got, exp));
endtask

// address phase that returns at the falling edge after acceptance
task automatic ahb_address(input logic [31:0] addr, input logic write);
	hsel = 1'b1;
	haddr = addr;
	hwrite = write;
	hsize = HSIZE_WORD;
	htrans = 2'b10;
	@(negedge HCLK);
	hsel = 1'b0;
	htrans = 2'b00;
endtask

// exactly AHB_WAIT low cycles before ready
task automatic wait_states();
	int i;
	for (i = 0; i < AHB_WAIT; i++)
	begin
		check_bit("hreadyout in wait state", hreadyout, 1'b0);
		@(negedge HCLK);
	end
	check_bit("hreadyout after wait states", hreadyout, 1'b1);
	check_bit("hresp", hresp, HRESP_OKAY);
endtask

task automatic ahb_write(input logic [31:0] addr, input bus_word_t data);
	tx_entry_t ent;
	ent.dest = addr[11:4];
	ent.data = data;
	ahb_address(addr, 1'b1);
	hwdata = data;
	wait_states();
	// queue keeps one slot free so extra words are dropped
	if (model_q.size() < TX_DEPTH - 1)
		model_q.push_back(ent);
endtask

task automatic ahb_read(input bus_word_t exp);
	ahb_address(32'h0, 1'b0);
	wait_states();
	check_word("hrdata", hrdata, exp);
endtask

`endif

//--- verification/tb_slc.sv
`timescale 1ns/1ps

module tb_slc;

	import slc_pkg::*;

	localparam string STIM_FILE = "verification/slc_stimulus.txt";

	logic HCLK = 1'b0;
	logic HRESETn;

	logic hsel;
	logic [31:0] haddr;
	logic hwrite;
	logic [2:0] hsize;
	logic [1:0] htrans;
	logic hready;
	bus_word_t hwdata;
	logic hreadyout;
	logic hresp;
	bus_word_t hrdata;

	node_addr_t tx_dest;
	bus_word_t tx_data;
	logic tx_pend;
	logic tx_req;
	logic tx_ack;
	logic tx_succ;
	logic tx_fail;
	logic tx_resp_ack;

	bus_word_t rx_data;
	logic rx_pend;
	logic rx_req;
	logic rx_ack;
	logic frame_complete;

	// words the DUT should still hold for the node
	tx_entry_t model_q[$];

	int fd;
	int n;
	int line_count = 0;
	int cycles = 0;
	int cycle_limit = 0;
	logic done;
	logic [8*256-1:0] line_buf;
	logic [7:0] cmd;
	logic [7:0] reply;
	logic [31:0] addr;
	bus_word_t data;
	node_addr_t dest;
	logic pend_bit;

	slc_top uut (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.hsel(hsel),
		.haddr(haddr),
		.hwrite(hwrite),
		.hsize(hsize),
		.htrans(htrans),
		.hready(hready),
		.hwdata(hwdata),
		.hreadyout(hreadyout),
		.hresp(hresp),
		.hrdata(hrdata),
		.tx_dest(tx_dest),
		.tx_data(tx_data),
		.tx_pend(tx_pend),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx_succ(tx_succ),
		.tx_fail(tx_fail),
		.tx_resp_ack(tx_resp_ack),
		.rx_data(rx_data),
		.rx_pend(rx_pend),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.frame_complete(frame_complete)
	);

	`include "tb_slc_tasks.svh"

	always #2 HCLK = ~HCLK;

	always @(posedge HCLK)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
			stop_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
	end

	function automatic logic next_same_dest();
		return (model_q.size() > 1) && (model_q[1].dest == model_q[0].dest);
	endfunction

	// node side of one transmit with an S or F reply
	task automatic node_transmit(input logic [7:0] answer, input node_addr_t exp_dest,
		input bus_word_t exp_data);
		int delay;
		while (tx_req !== 1'b1)
			@(negedge HCLK);
		check_dest("tx_dest", tx_dest, exp_dest);
		check_word("tx_data", tx_data, exp_data);
		check_bit("tx_pend", tx_pend, next_same_dest());
		delay = $urandom_range(3, 1);
		repeat (delay)
			@(negedge HCLK);
		check_bit("tx_req held until ack", tx_req, 1'b1);
		tx_ack = 1'b1;
		@(negedge HCLK);
		check_bit("tx_req after ack", tx_req, 1'b0);
		tx_ack = 1'b0;
		tx_succ = (answer == "S");
		tx_fail = (answer == "F");
		@(negedge HCLK);
		check_bit("tx_resp_ack rise", tx_resp_ack, 1'b1);
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		@(negedge HCLK);
		check_bit("tx_resp_ack fall", tx_resp_ack, 1'b0);
		if (answer == "F")
		begin
			// flushed queue leaves nothing to send
			model_q.delete();
			repeat (3)
			begin
				check_bit("tx_req after flush", tx_req, 1'b0);
				@(negedge HCLK);
			end
		end
		else
			void'(model_q.pop_front());
	endtask

	task automatic node_receive(input bus_word_t word, input logic pend);
		rx_data = word;
		rx_pend = pend;
		rx_req = 1'b1;
		@(negedge HCLK);
		while (rx_ack !== 1'b1)
			@(negedge HCLK);
		check_bit("frame_complete while acked", frame_complete, 1'b0);
		rx_req = 1'b0;
		@(negedge HCLK);
		check_bit("rx_ack after rx_req fall", rx_ack, 1'b0);
		check_bit("frame_complete", frame_complete, !pend);
		@(negedge HCLK);
		check_bit("frame_complete width", frame_complete, 1'b0);
	endtask

	initial
	begin
		void'($urandom(32'h5738_23b2));
		HRESETn = 1'b0;
		hsel = 1'b0;
		haddr = '0;
		hwrite = 1'b0;
		hsize = HSIZE_WORD;
		htrans = 2'b00;
		hready = 1'b1;
		hwdata = '0;
		tx_ack = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		rx_data = '0;
		rx_pend = 1'b0;
		rx_req = 1'b0;

		// timeout scales with the stimulus length
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
			stop_run("cannot open the stimulus file verification/slc_stimulus.txt");
		while (!$feof(fd))
		begin
			if ($fgets(line_buf, fd) > 0)
				line_count = line_count + 1;
		end
		$fclose(fd);
		cycle_limit = 60 * line_count;

		repeat (4)
			@(negedge HCLK);
		HRESETn = 1'b1;
		check_bit("hreadyout after reset", hreadyout, 1'b1);
		check_word("hrdata after reset", hrdata, '0);
		check_bit("tx_req after reset", tx_req, 1'b0);
		check_bit("rx_ack after reset", rx_ack, 1'b0);

		fd = $fopen(STIM_FILE, "r");
		done = 1'b0;
		while (!done)
		begin
			if ($fscanf(fd, " %c", cmd) != 1)
				done = 1'b1;
			else
			begin
				case (cmd)
					"#":
						n = $fgets(line_buf, fd);
					"W":
					begin
						n = $fscanf(fd, " %h %h", addr, data);
						if (n != 2)
							stop_run("malformed W line in the stimulus file");
						ahb_write(addr, data);
					end
					"R":
					begin
						n = $fscanf(fd, " %h", data);
						if (n != 1)
							stop_run("malformed R line in the stimulus file");
						ahb_read(data);
					end
					"X":
					begin
						n = $fscanf(fd, " %h %h", data, pend_bit);
						if (n != 2)
							stop_run("malformed X line in the stimulus file");
						node_receive(data, pend_bit);
					end
					"T":
					begin
						n = $fscanf(fd, " %c %h %h", reply, dest, data);
						if (n != 3 || (reply != "S" && reply != "F"))
							stop_run("malformed T line in the stimulus file");
						node_transmit(reply, dest, data);
					end
					default:
						stop_run($sformatf("unknown command %c in the stimulus file", cmd));
				endcase
			end
		end
		$fclose(fd);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- design/slc_top.sv
`timescale 1ns/1ps

module slc_top (
	input logic HCLK,
	input logic HRESETn,

	input logic hsel,
	input logic [31:0] haddr,
	input logic hwrite,
	input logic [2:0] hsize,
	input logic [1:0] htrans,
	input logic hready,
	input slc_pkg::bus_word_t hwdata,
	output logic hreadyout,
	output logic hresp,
	output slc_pkg::bus_word_t hrdata,

	output slc_pkg::node_addr_t tx_dest,
	output slc_pkg::bus_word_t tx_data,
	output logic tx_pend,
	output logic tx_req,
	input logic tx_ack,
	input logic tx_succ,
	input logic tx_fail,
	output logic tx_resp_ack,

	input slc_pkg::bus_word_t rx_data,
	input logic rx_pend,
	input logic rx_req,
	output logic rx_ack,
	output logic frame_complete
);

	import slc_pkg::*;

	tx_entry_t tx_new_entry;
	tx_entry_t tx_head_entry;
	logic tx_push;
	logic tx_pop;
	logic tx_flush;
	logic tx_empty;
	logic tx_full;

	rx_entry_t rx_in;
	bus_word_t rx_head;
	logic rx_push;
	logic rx_pop;
	logic rx_full;
	logic rx_empty;

	assign hresp = HRESP_OKAY;

	assign tx_dest = tx_head_entry.dest;
	assign tx_data = tx_head_entry.data;

	// node receive bundle
	assign rx_in.data = rx_data;
	assign rx_in.pend = rx_pend;

	layer_ctrl u_ctrl (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.hsel(hsel),
		.haddr(haddr),
		.hwrite(hwrite),
		.hsize(hsize),
		.htrans(htrans),
		.hready(hready),
		.hwdata(hwdata),
		.hreadyout(hreadyout),
		.hrdata(hrdata),
		.tx_push(tx_push),
		.tx_new_entry(tx_new_entry),
		.tx_pop(tx_pop),
		.tx_flush(tx_flush),
		.tx_empty(tx_empty),
		.tx_full(tx_full),
		.tx_ack(tx_ack),
		.tx_req(tx_req),
		.tx_resp_ack(tx_resp_ack),
		.tx_succ(tx_succ),
		.tx_fail(tx_fail),
		.rx_push(rx_push),
		.rx_pop(rx_pop),
		.rx_full(rx_full),
		.rx_empty(rx_empty),
		.rx_head(rx_head),
		.rx_req(rx_req),
		.rx_pend_in(rx_in.pend),
		.rx_ack(rx_ack),
		.frame_complete(frame_complete)
	);

	tx_queue u_tx_queue (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.push(tx_push),
		.new_entry(tx_new_entry),
		.pop(tx_pop),
		.flush(tx_flush),
		.head_entry(tx_head_entry),
		.empty(tx_empty),
		.full(tx_full),
		.pend(tx_pend)
	);

	rx_fifo u_rx_fifo (
		.HCLK(HCLK),
		.HRESETn(HRESETn),
		.push(rx_push),
		.push_data(rx_in.data),
		.pop(rx_pop),
		.head_data(rx_head),
		.full(rx_full),
		.empty(rx_empty)
	);

endmodule

//--- design/layer_ctrl.sv
`timescale 1ns/1ps

module layer_ctrl (
	input logic HCLK,
	input logic HRESETn,

	input logic hsel,
	input logic [31:0] haddr,
	input logic hwrite,
	input logic [2:0] hsize,
	input logic [1:0] htrans,
	input logic hready,
	input slc_pkg::bus_word_t hwdata,
	output logic hreadyout,
	output slc_pkg::bus_word_t hrdata,

	output logic tx_push,
	output slc_pkg::tx_entry_t tx_new_entry,
	output logic tx_pop,
	output logic tx_flush,
	input logic tx_empty,
	input logic tx_full,

	input logic tx_ack,
	output logic tx_req,
	output logic tx_resp_ack,
	input logic tx_succ,
	input logic tx_fail,

	output logic rx_push,
	output logic rx_pop,
	input logic rx_full,
	input logic rx_empty,
	input slc_pkg::bus_word_t rx_head,

	input logic rx_req,
	input logic rx_pend_in,
	output logic rx_ack,
	output logic frame_complete
);

	import slc_pkg::*;

	typedef logic [$clog2(AHB_WAIT+1)-1:0] wait_cnt_t;

	ahb_state_t ahb_state;
	tx_state_t tx_state;
	rx_state_t rx_state;

	wait_cnt_t wait_cnt;
	logic hwrite_q;
	logic xfer_start;
	bus_word_t rd_word;
	logic rx_pend_q;

	assign xfer_start = hsel && hready && htrans[1] && (hsize == HSIZE_WORD) &&
		(ahb_state == AHB_IDLE);

	// one push or pop per accepted AHB transfer
	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			ahb_state <= AHB_IDLE;
			wait_cnt <= '0;
			hwrite_q <= 1'b0;
			hreadyout <= 1'b1;
			hrdata <= '0;
			tx_push <= 1'b0;
			rx_pop <= 1'b0;
		end
		else
		begin
			case (ahb_state)
				AHB_IDLE:
				begin
					if (xfer_start)
					begin
						hwrite_q <= hwrite;
						hreadyout <= 1'b0;
						wait_cnt <= wait_cnt_t'(1);
						ahb_state <= AHB_LATCH;
					end
				end
				AHB_LATCH:
				begin
					// full queue drops the word
					tx_push <= hwrite_q && !tx_full;
					rx_pop <= !hwrite_q && !rx_empty;
					wait_cnt <= wait_cnt + 1'b1;
					ahb_state <= AHB_STROBE;
				end
				AHB_STROBE:
				begin
					tx_push <= 1'b0;
					rx_pop <= 1'b0;
					wait_cnt <= wait_cnt + 1'b1;
					ahb_state <= AHB_SETTLE;
				end
				AHB_SETTLE:
				begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == wait_cnt_t'(AHB_WAIT - 1))
						ahb_state <= AHB_RESPOND;
				end
				AHB_RESPOND:
				begin
					hrdata <= rd_word;
					hreadyout <= 1'b1;
					ahb_state <= AHB_IDLE;
				end
				default:
				begin
					ahb_state <= AHB_IDLE;
				end
			endcase
		end
	end

	// dest taken at acceptance and data one edge later
	// read word is captured before the pop
	always_ff @(posedge HCLK)
	begin
		if (xfer_start)
			tx_new_entry.dest <= haddr[11:4];
		if (ahb_state == AHB_LATCH)
		begin
			tx_new_entry.data <= hwdata;
			rd_word <= hwrite_q ? '0 : rx_head;
		end
	end

	assign tx_pop = (tx_state == TX_WAIT) && tx_ack;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			tx_state <= TX_IDLE;
			tx_req <= 1'b0;
			tx_resp_ack <= 1'b0;
			tx_flush <= 1'b0;
		end
		else
		begin
			if ((tx_succ || tx_fail) && !tx_resp_ack)
				tx_resp_ack <= 1'b1;
			else if (!(tx_succ || tx_fail) && tx_resp_ack)
				tx_resp_ack <= 1'b0;

			tx_flush <= tx_fail && !tx_resp_ack;

			case (tx_state)
				TX_IDLE:
				begin
					// hold off while a failure is still clearing the queue
					if (!tx_empty && !tx_ack && !tx_fail && !tx_flush)
					begin
						tx_req <= 1'b1;
						tx_state <= TX_WAIT;
					end
				end
				TX_WAIT:
				begin
					if (tx_ack || tx_flush)
					begin
						tx_req <= 1'b0;
						tx_state <= TX_IDLE;
					end
				end
				default:
				begin
					tx_state <= TX_IDLE;
				end
			endcase
		end
	end

	// word is written on the same edge that raises rx_ack
	assign rx_push = (rx_state == RX_IDLE) && rx_req && !rx_ack && !rx_full;

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			rx_state <= RX_IDLE;
			rx_ack <= 1'b0;
			rx_pend_q <= 1'b0;
			frame_complete <= 1'b0;
		end
		else
		begin
			frame_complete <= 1'b0;
			case (rx_state)
				RX_IDLE:
				begin
					if (rx_push)
					begin
						rx_ack <= 1'b1;
						rx_pend_q <= rx_pend_in;
						rx_state <= RX_WAIT;
					end
				end
				RX_WAIT:
				begin
					if (!rx_req)
					begin
						rx_ack <= 1'b0;
						frame_complete <= !rx_pend_q;
						rx_state <= RX_IDLE;
					end
				end
				default:
				begin
					rx_state <= RX_IDLE;
				end
			endcase
		end
	end

	a_tx_req_waits_ack_low: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(tx_ack && !tx_req) |=> !tx_req);

	a_rx_ack_needs_req: assert property (@(posedge HCLK) disable iff (!HRESETn)
		$rose(rx_ack) |-> $past(rx_req));

endmodule

//--- design/rx_fifo.sv
`timescale 1ns/1ps

module rx_fifo (
	input logic HCLK,
	input logic HRESETn,
	input logic push,
	input slc_pkg::bus_word_t push_data,
	input logic pop,
	output slc_pkg::bus_word_t head_data,
	output logic full,
	output logic empty
);

	import slc_pkg::*;

	bus_word_t mem [RX_DEPTH];

	rx_ptr_t rd_ptr;
	rx_ptr_t wr_ptr;
	logic [$clog2(RX_DEPTH+1)-1:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == RX_DEPTH);
	assign empty = (count == 0);

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// reads as zero when nothing is queued
	assign head_data = empty ? '0 : mem[rd_ptr];

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	a_no_push_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
		push |-> !full);

endmodule

//--- design/tx_queue.sv
`timescale 1ns/1ps

module tx_queue (
	input logic HCLK,
	input logic HRESETn,
	input logic push,
	input slc_pkg::tx_entry_t new_entry,
	input logic pop,
	input logic flush,
	output slc_pkg::tx_entry_t head_entry,
	output logic empty,
	output logic full,
	output logic pend
);

	import slc_pkg::*;

	tx_entry_t mem [TX_DEPTH];

	// head is the front entry, tail the next free slot
	tx_ptr_t head;
	tx_ptr_t tail;
	tx_ptr_t head_next;
	tx_ptr_t tail_next;

	assign head_next = head + 1'b1;
	assign tail_next = tail + 1'b1;

	// one slot stays free so head == tail means empty
	assign empty = (head == tail);
	assign full = (tail_next == head);

	assign head_entry = mem[head];

	// same destination on the entry behind the front one
	assign pend = !empty && (head_next != tail) && (mem[head_next].dest == mem[head].dest);

	always_ff @(posedge HCLK or negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			head <= '0;
			tail <= '0;
		end
		else
		begin
			if (push && !full)
				tail <= tail_next;

			if (flush)
				head <= tail;
			else if (pop && !empty)
				head <= head_next;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (push && !full)
			mem[tail] <= new_entry;
	end

	a_no_push_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
		push |-> !full);

	a_no_pop_empty: assert property (@(posedge HCLK) disable iff (!HRESETn)
		pop |-> !empty);

endmodule

//--- design/slc_pkg.sv
package slc_pkg;

	localparam int TX_DEPTH = 8;
	localparam int RX_DEPTH = 8;
	localparam int AHB_WAIT = 4;

	localparam logic [2:0] HSIZE_WORD = 3'b010;
	localparam logic HRESP_OKAY = 1'b0;

	typedef logic [31:0] bus_word_t;
	typedef logic [7:0] node_addr_t;

	typedef logic [$clog2(TX_DEPTH)-1:0] tx_ptr_t;
	typedef logic [$clog2(RX_DEPTH)-1:0] rx_ptr_t;

	// one transmit queue slot
	typedef struct packed {
		node_addr_t dest;
		bus_word_t data;
	} tx_entry_t;

	// what the node offers on its receive side
	typedef struct packed {
		bus_word_t data;
		logic pend;
	} rx_entry_t;

	typedef enum logic [2:0] {
		AHB_IDLE,
		AHB_LATCH,
		AHB_STROBE,
		AHB_SETTLE,
		AHB_RESPOND
	} ahb_state_t;

	typedef enum logic {
		TX_IDLE,
		TX_WAIT
	} tx_state_t;

	typedef enum logic {
		RX_IDLE,
		RX_WAIT
	} rx_state_t;

endpackage
